//--- verilog/csr_pkg.sv
package csr_pkg;

  // --------------------
  // Widths
  // --------------------

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // Encodings follow the low two bits of funct3
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

  typedef enum logic {
    TRAP_ECALL = 1'b0,
    TRAP_MRET  = 1'b1
  } trap_kind_e;

  // --------------------
  // CSR addresses
  // --------------------

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MVENDORID = 12'hf11;
  localparam csr_addr_t CSR_MARCHID   = 12'hf12;

  // --------------------
  // Architectural values
  // --------------------

  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // Environment call from M-mode
  localparam csr_data_t MCAUSE_ECALL_M = 32'd11;

  localparam csr_data_t MVENDORID_VAL = 32'h7973_7978;
  localparam csr_data_t MARCHID_VAL   = 32'h015f_de77;

endpackage

//--- verilog/csr_regs.sv
`timescale 1ns/1ps

module csr_regs #(
  parameter csr_pkg::csr_data_t MTVEC_RESET = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rst,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::csr_addr_t addr2,
  input  logic               wen,
  input  csr_pkg::csr_data_t wdata,
  input  csr_pkg::csr_data_t wdata2,
  input  logic               trap_enter,
  input  logic               trap_return,
  output csr_pkg::csr_data_t rdata,
  output csr_pkg::csr_data_t mtvec,
  output csr_pkg::csr_data_t mepc
);

  import csr_pkg::*;

  typedef logic [2:0] reg_idx_t;

  localparam reg_idx_t IDX_MSTATUS = 3'd0;
  localparam reg_idx_t IDX_MTVEC   = 3'd1;
  localparam reg_idx_t IDX_MEPC    = 3'd2;
  localparam reg_idx_t IDX_MCAUSE  = 3'd3;
  localparam reg_idx_t IDX_NONE    = 3'd4;

  csr_data_t csr_q [0:3];
  reg_idx_t  idx1;
  reg_idx_t  idx2;
  logic      mie;
  logic      mpie;

  // Read-only and unknown addresses map to no register
  function automatic reg_idx_t decode_idx(input csr_addr_t a);
    reg_idx_t idx;
    case (a)
      CSR_MSTATUS: idx = IDX_MSTATUS;
      CSR_MTVEC:   idx = IDX_MTVEC;
      CSR_MEPC:    idx = IDX_MEPC;
      CSR_MCAUSE:  idx = IDX_MCAUSE;
      default:     idx = IDX_NONE;
    endcase
    return idx;
  endfunction

  assign idx1 = decode_idx(addr);
  assign idx2 = decode_idx(addr2);

  assign mie  = csr_q[IDX_MSTATUS[1:0]][MSTATUS_MIE_BIT];
  assign mpie = csr_q[IDX_MSTATUS[1:0]][MSTATUS_MPIE_BIT];

  // --------------------
  // Read path
  // --------------------

  always_comb begin
    case (addr)
      CSR_MSTATUS:   rdata = csr_q[IDX_MSTATUS[1:0]];
      CSR_MTVEC:     rdata = csr_q[IDX_MTVEC[1:0]];
      CSR_MEPC:      rdata = csr_q[IDX_MEPC[1:0]];
      CSR_MCAUSE:    rdata = csr_q[IDX_MCAUSE[1:0]];
      CSR_MVENDORID: rdata = MVENDORID_VAL;
      CSR_MARCHID:   rdata = MARCHID_VAL;
      default:       rdata = '0;
    endcase
  end

  assign mtvec = csr_q[IDX_MTVEC[1:0]];
  assign mepc  = csr_q[IDX_MEPC[1:0]];

  // --------------------
  // Write path
  // --------------------

  // The mstatus trap updates come last so they win over a port write
  always_ff @(posedge clk) begin
    if (rst) begin
      csr_q[IDX_MSTATUS[1:0]] <= '0;
      csr_q[IDX_MTVEC[1:0]]   <= MTVEC_RESET;
      csr_q[IDX_MEPC[1:0]]    <= '0;
      csr_q[IDX_MCAUSE[1:0]]  <= '0;
    end else begin
      if (wen) begin
        if (idx1 != IDX_NONE) begin
          csr_q[idx1[1:0]] <= wdata;
        end
        if (idx2 != IDX_NONE) begin
          csr_q[idx2[1:0]] <= wdata2;
        end
      end
      if (trap_enter) begin
        csr_q[IDX_MSTATUS[1:0]][MSTATUS_MPIE_BIT] <= mie;
        csr_q[IDX_MSTATUS[1:0]][MSTATUS_MIE_BIT]  <= 1'b0;
      end else if (trap_return) begin
        csr_q[IDX_MSTATUS[1:0]][MSTATUS_MIE_BIT]  <= mpie;
        csr_q[IDX_MSTATUS[1:0]][MSTATUS_MPIE_BIT] <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/csr_op_unit.sv
`timescale 1ns/1ps

module csr_op_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               op_start,
  input  csr_pkg::csr_op_e   op,
  input  csr_pkg::csr_addr_t op_addr,
  input  csr_pkg::csr_data_t op_src,
  input  logic               grant,
  input  csr_pkg::csr_data_t rdata,
  output logic               op_busy,
  output logic               op_done,
  output csr_pkg::csr_data_t op_result,
  output logic               req,
  output csr_pkg::csr_addr_t addr,
  output logic               wen,
  output csr_pkg::csr_data_t wdata
);

  import csr_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_WAIT
  } state_e;

  state_e    state_q;
  csr_op_e   op_q;
  csr_addr_t addr_q;
  csr_data_t src_q;
  logic      no_write;

  // --------------------
  // Control
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      op_done <= 1'b0;
    end else begin
      op_done <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (op_start) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (grant) begin
            state_q <= S_IDLE;
            op_done <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && op_start) begin
      op_q   <= op;
      addr_q <= op_addr;
      src_q  <= op_src;
    end
    if (state_q == S_WAIT && grant) begin
      op_result <= rdata;
    end
  end

  // --------------------
  // Port drive
  // --------------------

  assign op_busy = (state_q == S_WAIT);
  assign req     = op_busy;
  assign addr    = addr_q;

  // csrrs and csrrc with a zero source must not write
  assign no_write = (op_q != CSR_RW) && (src_q == '0);
  assign wen      = op_busy && !no_write;

  always_comb begin
    case (op_q)
      CSR_RS:  wdata = rdata | src_q;
      CSR_RC:  wdata = rdata & ~src_q;
      default: wdata = src_q;
    endcase
  end

endmodule

//--- verilog/trap_unit.sv
`timescale 1ns/1ps

module trap_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                trap_start,
  input  csr_pkg::trap_kind_e trap_kind,
  input  csr_pkg::csr_data_t  trap_pc,
  input  logic                grant,
  input  csr_pkg::csr_data_t  mtvec,
  input  csr_pkg::csr_data_t  mepc,
  output logic                trap_busy,
  output logic                redirect_valid,
  output csr_pkg::csr_data_t  redirect_pc,
  output logic                req,
  output csr_pkg::csr_addr_t  addr,
  output csr_pkg::csr_addr_t  addr2,
  output logic                wen,
  output csr_pkg::csr_data_t  wdata,
  output csr_pkg::csr_data_t  wdata2,
  output logic                trap_enter,
  output logic                trap_return
);

  import csr_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_WAIT
  } state_e;

  state_e     state_q;
  trap_kind_e kind_q;
  csr_data_t  pc_q;
  logic       is_ecall;

  // --------------------
  // Control
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= S_IDLE;
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (trap_start) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (grant) begin
            state_q        <= S_IDLE;
            redirect_valid <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && trap_start) begin
      kind_q <= trap_kind;
      pc_q   <= trap_pc;
    end
    // Ecall jumps to the handler, mret back to the saved PC
    if (state_q == S_WAIT && grant) begin
      redirect_pc <= is_ecall ? mtvec : mepc;
    end
  end

  // --------------------
  // Port drive
  // --------------------

  assign trap_busy = (state_q == S_WAIT);
  assign req       = trap_busy;
  assign is_ecall  = (kind_q == TRAP_ECALL);

  assign addr   = CSR_MEPC;
  assign addr2  = CSR_MCAUSE;
  assign wdata  = pc_q;
  assign wdata2 = MCAUSE_ECALL_M;

  assign wen         = trap_busy && is_ecall;
  assign trap_enter  = trap_busy && is_ecall;
  assign trap_return = trap_busy && !is_ecall;

endmodule

//--- verilog/csr_arbiter.sv
`timescale 1ns/1ps

module csr_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  logic               op_req,
  input  logic               trap_req,
  input  csr_pkg::csr_addr_t op_addr,
  input  logic               op_wen,
  input  csr_pkg::csr_data_t op_wdata,
  input  csr_pkg::csr_addr_t trap_addr,
  input  csr_pkg::csr_addr_t trap_addr2,
  input  logic               trap_wen,
  input  csr_pkg::csr_data_t trap_wdata,
  input  csr_pkg::csr_data_t trap_wdata2,
  input  logic               trap_enter_req,
  input  logic               trap_return_req,
  output logic               op_grant,
  output logic               trap_grant,
  output csr_pkg::csr_addr_t addr,
  output csr_pkg::csr_addr_t addr2,
  output logic               wen,
  output csr_pkg::csr_data_t wdata,
  output csr_pkg::csr_data_t wdata2,
  output logic               trap_enter,
  output logic               trap_return
);

  import csr_pkg::*;

  // Decodes to no register in csr_regs, so the second port writes nothing
  localparam csr_addr_t ADDR_UNUSED = 12'h000;

  // Set when the op unit won the last grant
  logic last_op_q;

  assign trap_grant = trap_req && (!op_req || last_op_q);
  assign op_grant   = op_req && !trap_grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_op_q <= 1'b1;
    end else if (op_grant || trap_grant) begin
      last_op_q <= op_grant;
    end
  end

  assign addr   = trap_grant ? trap_addr : op_addr;
  assign wdata  = trap_grant ? trap_wdata : op_wdata;
  assign addr2  = trap_grant ? trap_addr2 : ADDR_UNUSED;
  assign wdata2 = trap_grant ? trap_wdata2 : '0;

  assign wen         = (op_grant && op_wen) || (trap_grant && trap_wen);
  assign trap_enter  = trap_grant && trap_enter_req;
  assign trap_return = trap_grant && trap_return_req;

endmodule

//--- verilog/csr_top.sv
`timescale 1ns/1ps

module csr_top #(
  parameter csr_pkg::csr_data_t MTVEC_RESET = 32'h8000_0100
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                op_start,
  input  csr_pkg::csr_op_e    op,
  input  csr_pkg::csr_addr_t  op_addr,
  input  csr_pkg::csr_data_t  op_src,
  output logic                op_busy,
  output logic                op_done,
  output csr_pkg::csr_data_t  op_result,
  input  logic                trap_start,
  input  csr_pkg::trap_kind_e trap_kind,
  input  csr_pkg::csr_data_t  trap_pc,
  output logic                trap_busy,
  output logic                redirect_valid,
  output csr_pkg::csr_data_t  redirect_pc
);

  import csr_pkg::*;

  // --------------------
  // Client side
  // --------------------

  logic      op_req;
  logic      op_grant;
  csr_addr_t op_addr_w;
  logic      op_wen;
  csr_data_t op_wdata;

  logic      trap_req;
  logic      trap_grant;
  csr_addr_t trap_addr;
  csr_addr_t trap_addr2;
  logic      trap_wen;
  csr_data_t trap_wdata;
  csr_data_t trap_wdata2;
  logic      trap_enter_req;
  logic      trap_return_req;

  // --------------------
  // Register-file port
  // --------------------

  csr_addr_t rf_addr;
  csr_addr_t rf_addr2;
  logic      rf_wen;
  csr_data_t rf_wdata;
  csr_data_t rf_wdata2;
  logic      rf_trap_enter;
  logic      rf_trap_return;
  csr_data_t rf_rdata;
  csr_data_t mtvec;
  csr_data_t mepc;

  csr_op_unit u_op_unit (
    .clk       (clk),
    .rst       (rst),
    .op_start  (op_start),
    .op        (op),
    .op_addr   (op_addr),
    .op_src    (op_src),
    .grant     (op_grant),
    .rdata     (rf_rdata),
    .op_busy   (op_busy),
    .op_done   (op_done),
    .op_result (op_result),
    .req       (op_req),
    .addr      (op_addr_w),
    .wen       (op_wen),
    .wdata     (op_wdata)
  );

  trap_unit u_trap_unit (
    .clk            (clk),
    .rst            (rst),
    .trap_start     (trap_start),
    .trap_kind      (trap_kind),
    .trap_pc        (trap_pc),
    .grant          (trap_grant),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .trap_busy      (trap_busy),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .req            (trap_req),
    .addr           (trap_addr),
    .addr2          (trap_addr2),
    .wen            (trap_wen),
    .wdata          (trap_wdata),
    .wdata2         (trap_wdata2),
    .trap_enter     (trap_enter_req),
    .trap_return    (trap_return_req)
  );

  csr_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .op_req          (op_req),
    .trap_req        (trap_req),
    .op_addr         (op_addr_w),
    .op_wen          (op_wen),
    .op_wdata        (op_wdata),
    .trap_addr       (trap_addr),
    .trap_addr2      (trap_addr2),
    .trap_wen        (trap_wen),
    .trap_wdata      (trap_wdata),
    .trap_wdata2     (trap_wdata2),
    .trap_enter_req  (trap_enter_req),
    .trap_return_req (trap_return_req),
    .op_grant        (op_grant),
    .trap_grant      (trap_grant),
    .addr            (rf_addr),
    .addr2           (rf_addr2),
    .wen             (rf_wen),
    .wdata           (rf_wdata),
    .wdata2          (rf_wdata2),
    .trap_enter      (rf_trap_enter),
    .trap_return     (rf_trap_return)
  );

  csr_regs #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_regs (
    .clk         (clk),
    .rst         (rst),
    .addr        (rf_addr),
    .addr2       (rf_addr2),
    .wen         (rf_wen),
    .wdata       (rf_wdata),
    .wdata2      (rf_wdata2),
    .trap_enter  (rf_trap_enter),
    .trap_return (rf_trap_return),
    .rdata       (rf_rdata),
    .mtvec       (mtvec),
    .mepc        (mepc)
  );

endmodule

//--- dv/csr_tb.sv
`timescale 1ns/1ps

module csr_tb;

  import csr_pkg::*;

  localparam csr_data_t MTVEC_RESET = 32'h0000_1a40;
  localparam int WAIT_LIMIT = 20;
  // Six tests take about 230 cycles together
  localparam int TEST_CYCLES    = 240;
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  logic       clk = 1'b0;
  logic       rst;
  logic       op_start;
  csr_op_e    op;
  csr_addr_t  op_addr;
  csr_data_t  op_src;
  logic       op_busy;
  logic       op_done;
  csr_data_t  op_result;
  logic       trap_start;
  trap_kind_e trap_kind;
  csr_data_t  trap_pc;
  logic       trap_busy;
  logic       redirect_valid;
  csr_data_t  redirect_pc;

  // Reference model of the four writable CSRs
  csr_data_t m_mstatus = '0;
  csr_data_t m_mtvec   = MTVEC_RESET;
  csr_data_t m_mepc    = '0;
  csr_data_t m_mcause  = '0;

  logic [31:0] lfsr_state = 32'hfac2ed13;
  int          cycle      = 0;
  int          errors     = 0;
  int          mon_errors = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  logic        last_op    = 1'b1;
  logic        op_pending   = 1'b0;
  logic        trap_pending = 1'b0;
  csr_op_e     pend_op;
  csr_addr_t   pend_addr;
  csr_data_t   pend_src;
  trap_kind_e  pend_kind;
  csr_data_t   pend_pc;
  int          op_t0;
  int          trap_t0;
  int          op_exp_lat;
  int          trap_exp_lat;
  int          op_lat;
  int          trap_lat;

  csr_top #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_dut (
    .clk            (clk),
    .rst            (rst),
    .op_start       (op_start),
    .op             (op),
    .op_addr        (op_addr),
    .op_src         (op_src),
    .op_busy        (op_busy),
    .op_done        (op_done),
    .op_result      (op_result),
    .trap_start     (trap_start),
    .trap_kind      (trap_kind),
    .trap_pc        (trap_pc),
    .trap_busy      (trap_busy),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  always #5 clk = ~clk;

  // --------------------
  // Random stimulus
  // --------------------

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic csr_addr_t rand_writable_addr();
    logic [31:0] sel;
    sel = rand_bits(2);
    case (sel)
      32'd0:   return CSR_MSTATUS;
      32'd1:   return CSR_MTVEC;
      32'd2:   return CSR_MEPC;
      default: return CSR_MCAUSE;
    endcase
  endfunction

  function automatic csr_op_e rand_op();
    logic [31:0] sel;
    sel = rand_bits(2);
    case (sel)
      32'd1:   return CSR_RS;
      32'd2:   return CSR_RC;
      default: return CSR_RW;
    endcase
  endfunction

  // A quarter of the sources are zero to reach the no-write rule
  function automatic csr_data_t rand_src();
    logic [31:0] sel;
    sel = rand_bits(2);
    if (sel == 32'd0) begin
      return '0;
    end
    return rand_bits(32);
  endfunction

  // --------------------
  // Reference model
  // --------------------

  function automatic csr_data_t model_read(input csr_addr_t a);
    case (a)
      CSR_MSTATUS:   return m_mstatus;
      CSR_MTVEC:     return m_mtvec;
      CSR_MEPC:      return m_mepc;
      CSR_MCAUSE:    return m_mcause;
      CSR_MVENDORID: return MVENDORID_VAL;
      CSR_MARCHID:   return MARCHID_VAL;
      default:       return '0;
    endcase
  endfunction

  task automatic model_op(input csr_op_e o, input csr_addr_t a, input csr_data_t s);
    csr_data_t old_val;
    csr_data_t new_val;
    old_val = model_read(a);
    case (o)
      CSR_RS:  new_val = old_val | s;
      CSR_RC:  new_val = old_val & ~s;
      default: new_val = s;
    endcase
    if (o == CSR_RW || s != '0) begin
      case (a)
        CSR_MSTATUS: m_mstatus = new_val;
        CSR_MTVEC:   m_mtvec = new_val;
        CSR_MEPC:    m_mepc = new_val;
        CSR_MCAUSE:  m_mcause = new_val;
        default:     ;
      endcase
    end
  endtask

  task automatic model_trap(input trap_kind_e kind, input csr_data_t pc);
    if (kind == TRAP_ECALL) begin
      m_mepc = pc;
      m_mcause = MCAUSE_ECALL_M;
      m_mstatus[MSTATUS_MPIE_BIT] = m_mstatus[MSTATUS_MIE_BIT];
      m_mstatus[MSTATUS_MIE_BIT] = 1'b0;
    end else begin
      m_mstatus[MSTATUS_MIE_BIT] = m_mstatus[MSTATUS_MPIE_BIT];
      m_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
    end
  endtask

  function automatic int check_value(input string name, input csr_data_t exp,
                                     input csr_data_t act);
    assert (act === exp) else begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      return 1;
    end
    return 0;
  endfunction

  // --------------------
  // Monitor and timeout
  // --------------------

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a request never completed", cycle);
      $display("Testbench failed");
      $finish;
    end else if (rst) begin
      last_op = 1'b1;
      op_pending = 1'b0;
      trap_pending = 1'b0;
    end else begin
      if (op_done) begin
        op_lat = cycle - op_t0;
        assert (op_lat == op_exp_lat) else begin
          $display("Mismatch at %0t: op_done latency expected %0d, got %0d",
                   $time, op_exp_lat, op_lat);
          mon_errors++;
        end
        mon_errors += check_value("op_result", model_read(pend_addr), op_result);
        model_op(pend_op, pend_addr, pend_src);
        last_op = 1'b1;
        op_pending = 1'b0;
      end
      if (redirect_valid) begin
        trap_lat = cycle - trap_t0;
        assert (trap_lat == trap_exp_lat) else begin
          $display("Mismatch at %0t: redirect_valid latency expected %0d, got %0d",
                   $time, trap_exp_lat, trap_lat);
          mon_errors++;
        end
        mon_errors += check_value("redirect_pc",
                                  pend_kind == TRAP_ECALL ? m_mtvec : m_mepc, redirect_pc);
        model_trap(pend_kind, pend_pc);
        last_op = 1'b0;
        trap_pending = 1'b0;
      end
      // Busy is high from the edge that takes the start until the done pulse
      assert (op_busy === op_pending) else begin
        $display("Mismatch at %0t: op_busy expected %b, got %b",
                 $time, op_pending, op_busy);
        mon_errors++;
      end
      assert (trap_busy === trap_pending) else begin
        $display("Mismatch at %0t: trap_busy expected %b, got %b",
                 $time, trap_pending, trap_busy);
        mon_errors++;
      end
      // The client that did not win last gets a contested grant
      if (op_start && !op_pending) begin
        op_t0 = cycle;
        pend_op = op;
        pend_addr = op_addr;
        pend_src = op_src;
        op_exp_lat = (trap_start && !trap_pending && last_op) ? 3 : 2;
      end
      if (trap_start && !trap_pending) begin
        trap_t0 = cycle;
        pend_kind = trap_kind;
        pend_pc = trap_pc;
        trap_exp_lat = (op_start && !op_pending && !last_op) ? 3 : 2;
      end
      if (op_start) begin
        op_pending = 1'b1;
      end
      if (trap_start) begin
        trap_pending = 1'b1;
      end
    end
  end

  // --------------------
  // Drivers
  // --------------------

  // Called 1 ns after a rising edge, returns 1 ns after the edge following the done
  task automatic run_op(input csr_op_e o, input csr_addr_t a, input csr_data_t s,
                        output csr_data_t res);
    int n;
    op_start = 1'b1;
    op = o;
    op_addr = a;
    op_src = s;
    @(posedge clk);
    #1;
    op_start = 1'b0;
    n = 0;
    while (!op_done && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (n < WAIT_LIMIT) else begin
      $display("op_done did not arrive within %0d cycles", WAIT_LIMIT);
      errors++;
    end
    res = op_result;
    @(posedge clk);
    #1;
  endtask

  task automatic run_trap(input trap_kind_e k, input csr_data_t pc, output csr_data_t res);
    int n;
    trap_start = 1'b1;
    trap_kind = k;
    trap_pc = pc;
    @(posedge clk);
    #1;
    trap_start = 1'b0;
    n = 0;
    while (!redirect_valid && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (n < WAIT_LIMIT) else begin
      $display("redirect_valid did not arrive within %0d cycles", WAIT_LIMIT);
      errors++;
    end
    res = redirect_pc;
    @(posedge clk);
    #1;
  endtask

  task automatic run_both(input csr_op_e o, input csr_addr_t a, input csr_data_t s,
                          input trap_kind_e k, input csr_data_t pc);
    int   n;
    logic got_op;
    logic got_trap;
    op_start = 1'b1;
    op = o;
    op_addr = a;
    op_src = s;
    trap_start = 1'b1;
    trap_kind = k;
    trap_pc = pc;
    @(posedge clk);
    #1;
    op_start = 1'b0;
    trap_start = 1'b0;
    n = 0;
    got_op = 1'b0;
    got_trap = 1'b0;
    while (!(got_op && got_trap) && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
      got_op = got_op | op_done;
      got_trap = got_trap | redirect_valid;
    end
    assert (got_op && got_trap) else begin
      $display("Contested requests did not both complete within %0d cycles", WAIT_LIMIT);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  function automatic int total_errors();
    return errors + mon_errors;
  endfunction

  task automatic end_test(input string name, input int e0);
    if (total_errors() == e0) begin
      pass_count++;
      $display("Test %s: ok", name);
    end else begin
      fail_count++;
      $display("Test %s: %0d errors", name, total_errors() - e0);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  initial begin
    csr_data_t  res;
    csr_data_t  pc;
    csr_data_t  ms_before;
    csr_data_t  exp_ms;
    logic [31:0] sel;
    trap_kind_e k;
    int         e0;
    rst = 1'b1;
    op_start = 1'b0;
    op = CSR_RW;
    op_addr = '0;
    op_src = '0;
    trap_start = 1'b0;
    trap_kind = TRAP_ECALL;
    trap_pc = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (!op_busy && !trap_busy && !op_done && !redirect_valid) else begin
      $display("Busy or done outputs are not clear after reset");
      errors++;
    end

    e0 = total_errors();
    run_op(CSR_RS, CSR_MSTATUS, '0, res);
    errors += check_value("mstatus", '0, res);
    run_op(CSR_RS, CSR_MTVEC, '0, res);
    errors += check_value("mtvec", MTVEC_RESET, res);
    run_op(CSR_RS, CSR_MEPC, '0, res);
    errors += check_value("mepc", '0, res);
    run_op(CSR_RS, CSR_MCAUSE, '0, res);
    errors += check_value("mcause", '0, res);
    run_op(CSR_RS, CSR_MVENDORID, '0, res);
    errors += check_value("mvendorid", MVENDORID_VAL, res);
    run_op(CSR_RS, CSR_MARCHID, '0, res);
    errors += check_value("marchid", MARCHID_VAL, res);
    end_test("reset values", e0);

    e0 = total_errors();
    repeat (40) begin
      run_op(rand_op(), rand_writable_addr(), rand_src(), res);
    end
    end_test("csr instructions", e0);

    e0 = total_errors();
    run_op(CSR_RW, CSR_MVENDORID, rand_bits(32), res);
    run_op(CSR_RS, CSR_MARCHID, 32'hffff_ffff, res);
    run_op(CSR_RW, 12'h7c0, rand_bits(32), res);
    run_op(CSR_RS, CSR_MVENDORID, '0, res);
    errors += check_value("mvendorid", MVENDORID_VAL, res);
    run_op(CSR_RS, CSR_MARCHID, '0, res);
    errors += check_value("marchid", MARCHID_VAL, res);
    run_op(CSR_RS, 12'h7c0, '0, res);
    errors += check_value("unknown csr", '0, res);
    // The monitor compares each read with the unchanged model
    run_op(CSR_RS, CSR_MSTATUS, '0, res);
    run_op(CSR_RS, CSR_MTVEC, '0, res);
    run_op(CSR_RS, CSR_MEPC, '0, res);
    run_op(CSR_RS, CSR_MCAUSE, '0, res);
    end_test("read-only and unknown", e0);

    e0 = total_errors();
    run_op(CSR_RS, CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT, res);
    ms_before = m_mstatus;
    pc = rand_bits(32);
    run_trap(TRAP_ECALL, pc, res);
    run_op(CSR_RS, CSR_MEPC, '0, res);
    errors += check_value("mepc", pc, res);
    run_op(CSR_RS, CSR_MCAUSE, '0, res);
    errors += check_value("mcause", 32'd11, res);
    exp_ms = ms_before;
    exp_ms[MSTATUS_MPIE_BIT] = 1'b1;
    exp_ms[MSTATUS_MIE_BIT] = 1'b0;
    run_op(CSR_RS, CSR_MSTATUS, '0, res);
    errors += check_value("mstatus", exp_ms, res);
    end_test("ecall", e0);

    e0 = total_errors();
    ms_before = m_mstatus;
    run_trap(TRAP_MRET, '0, res);
    errors += check_value("redirect_pc", pc, res);
    exp_ms = ms_before;
    exp_ms[MSTATUS_MIE_BIT] = ms_before[MSTATUS_MPIE_BIT];
    exp_ms[MSTATUS_MPIE_BIT] = 1'b1;
    run_op(CSR_RS, CSR_MSTATUS, '0, res);
    errors += check_value("mstatus", exp_ms, res);
    end_test("mret", e0);

    e0 = total_errors();
    repeat (10) begin
      sel = rand_bits(1);
      k = sel[0] ? TRAP_MRET : TRAP_ECALL;
      run_both(rand_op(), rand_writable_addr(), rand_src(), k, rand_bits(32));
      assert ((op_lat == 2 && trap_lat == 3) || (op_lat == 3 && trap_lat == 2)) else begin
        $display("Contested requests took %0d and %0d cycles instead of 2 and 3",
                 op_lat, trap_lat);
        errors++;
      end
    end
    end_test("arbitration", e0);

    $display("Tests passed: %0d, failed: %0d, errors: %0d",
             pass_count, fail_count, total_errors());
    if (fail_count == 0 && total_errors() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
verilog/csr_pkg.sv
verilog/csr_regs.sv
verilog/csr_op_unit.sv
verilog/trap_unit.sv
verilog/csr_arbiter.sv
verilog/csr_top.sv
dv/csr_tb.sv

//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
TOP      = csr_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
